/* design/fcmp_pkg.sv */
// Floating-point compare unit shared definitions
// IEEE single layout, compare operation codes, class mask bit order
// and the register map of the Wishbone slave
package fcmp_pkg;

    // IEEE 754 single precision fields, sign on top
    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] significand;
    } float_t;

    // The register block sees a raw bus word, the datapath sees fields
    typedef union packed {
        logic [31:0] raw;
        float_t      fields;
    } float_word_u;

    typedef enum logic [1:0] {
        FP_EQ = 2'b00,
        FP_LT = 2'b01,
        FP_LE = 2'b10,
        FP_GT = 2'b11
    } fcomp_uop_t;

    // Ten-class mask in the usual fclass bit order
    typedef logic [9:0] fclass_t;

    localparam int CLASS_NEG_INF  = 0;
    localparam int CLASS_NEG_NORM = 1;
    localparam int CLASS_NEG_SUB  = 2;
    localparam int CLASS_NEG_ZERO = 3;
    localparam int CLASS_POS_ZERO = 4;
    localparam int CLASS_POS_SUB  = 5;
    localparam int CLASS_POS_NORM = 6;
    localparam int CLASS_POS_INF  = 7;
    localparam int CLASS_SNAN     = 8;
    localparam int CLASS_QNAN     = 9;

    localparam logic [31:0] CANONICAL_NAN = 32'h7FC0_0000;

    // Byte offsets of the slave registers
    localparam logic [7:0] ADDR_OPA    = 8'h00;
    localparam logic [7:0] ADDR_OPB    = 8'h04;
    localparam logic [7:0] ADDR_CTRL   = 8'h08;
    localparam logic [7:0] ADDR_RESULT = 8'h0C;
    localparam logic [7:0] ADDR_STATUS = 8'h10;
    localparam logic [7:0] ADDR_CLASS  = 8'h14;

    // CTRL and STATUS bit positions
    localparam int CTRL_OP_LSB        = 0;
    localparam int CTRL_OP_MSB        = 1;
    localparam int CTRL_FLAG_BIT      = 2;
    localparam int STATUS_DONE_BIT    = 0;
    localparam int STATUS_INVALID_BIT = 1;

endpackage : fcmp_pkg

/* design/fcmp_req_if.sv */
// Compare request and response bundle
// Carries operands and control from the register block to the comparator
// and brings the result and the invalid exception back
`timescale 1ns/1ps

interface fcmp_req_if import fcmp_pkg::*; ();

    // Request side
    float_word_u operand_a;
    float_word_u operand_b;
    fcomp_uop_t  operation;
    logic        flag;
    logic        req_valid;

    // Response side, valid in the same cycle as the request
    float_word_u result;
    logic        invalid_op;
    logic        rsp_valid;

    modport requester (
        output operand_a, operand_b, operation, flag, req_valid,
        input  result, invalid_op, rsp_valid
    );

    modport responder (
        input  operand_a, operand_b, operation, flag, req_valid,
        output result, invalid_op, rsp_valid
    );

endinterface : fcmp_req_if

/* design/float_classifier.sv */
// Single-precision operand classifier
// Flags NaN and signaling NaN and builds the one-hot fclass mask
`timescale 1ns/1ps

module float_classifier import fcmp_pkg::*; (
    input  float_word_u operand_i,
    output logic        is_nan_o,
    output logic        is_snan_o,
    output fclass_t     class_o
);

    logic exp_ones;
    logic exp_zero;
    logic sig_zero;
    logic sign;

    assign sign     = operand_i.fields.sign;
    assign exp_ones = &operand_i.fields.exponent;
    assign exp_zero = ~|operand_i.fields.exponent;
    assign sig_zero = ~|operand_i.fields.significand;

    // A NaN has a maximal exponent and a non-zero significand
    assign is_nan_o  = exp_ones & ~sig_zero;
    // The quiet bit is the top significand bit
    assign is_snan_o = is_nan_o & ~operand_i.fields.significand[22];

    always_comb begin
        class_o = '0;
        if (is_nan_o) begin
            class_o[CLASS_SNAN] = ~operand_i.fields.significand[22];
            class_o[CLASS_QNAN] = operand_i.fields.significand[22];
        end else if (exp_ones) begin
            class_o[sign ? CLASS_NEG_INF : CLASS_POS_INF] = 1'b1;
        end else if (exp_zero && sig_zero) begin
            class_o[sign ? CLASS_NEG_ZERO : CLASS_POS_ZERO] = 1'b1;
        end else if (exp_zero) begin
            class_o[sign ? CLASS_NEG_SUB : CLASS_POS_SUB] = 1'b1;
        end else begin
            class_o[sign ? CLASS_NEG_NORM : CLASS_POS_NORM] = 1'b1;
        end
    end

endmodule : float_classifier

/* design/float_comparator.sv */
// Floating-point compare and min/max unit
// Evaluates EQ, LT, LE and GT as a 0/1 flag or selects the winning
// operand, with NaN propagation and the invalid-operation exception.
// Purely combinational, the response is valid with the request
`timescale 1ns/1ps

module float_comparator import fcmp_pkg::*; (
    fcmp_req_if.responder req,
    input  logic          is_nan_a_i,
    input  logic          is_nan_b_i,
    input  logic          is_snan_a_i,
    input  logic          is_snan_b_i
);

    float_t op_a;
    float_t op_b;

    logic exp_lt;
    logic exp_eq;
    logic sig_lt;
    logic sig_eq;
    logic mag_lt;
    logic mag_eq;
    logic both_zero;
    logic a_eq_b;
    logic a_lt_b;
    logic a_gt_b;
    logic any_nan;
    logic any_snan;
    logic select_mode;

    float_word_u ordered_result;
    float_word_u nan_result;

    assign op_a = req.operand_a.fields;
    assign op_b = req.operand_b.fields;

    //==========================================================================
    // Field comparisons
    //==========================================================================

    // Exponent and significand are compared on their own, then merged
    assign exp_lt = op_a.exponent < op_b.exponent;
    assign exp_eq = op_a.exponent == op_b.exponent;
    assign sig_lt = op_a.significand < op_b.significand;
    assign sig_eq = op_a.significand == op_b.significand;

    // Magnitude order ignoring the sign
    assign mag_lt = exp_lt | (exp_eq & sig_lt);
    assign mag_eq = exp_eq & sig_eq;

    // Both zero means exponent and significand are clear on each side
    assign both_zero = ~|{op_a.exponent, op_a.significand, op_b.exponent, op_b.significand};

    // Identical bit patterns, or a pair of zeros with any signs
    assign a_eq_b = (req.operand_a.raw == req.operand_b.raw) | both_zero;

    always_comb begin
        case ({op_a.sign, op_b.sign})
            2'b00:   a_lt_b = mag_lt;
            // Negative against positive, except -0 versus +0
            2'b10:   a_lt_b = ~both_zero;
            2'b01:   a_lt_b = 1'b0;
            // Two negatives, the larger magnitude is the smaller value
            default: a_lt_b = ~mag_lt & ~mag_eq;
        endcase
    end

    assign a_gt_b = ~a_lt_b & ~a_eq_b;

    //==========================================================================
    // Ordered result
    //==========================================================================

    // Only LT and GT with the flag clear pick an operand (min and max)
    assign select_mode = ~req.flag & ((req.operation == FP_LT) | (req.operation == FP_GT));

    always_comb begin
        ordered_result.raw = '0;
        case (req.operation)
            FP_EQ: ordered_result.raw = {31'b0, a_eq_b};
            FP_LE: ordered_result.raw = {31'b0, a_lt_b | a_eq_b};
            FP_LT: begin
                if (req.flag) begin
                    ordered_result.raw = {31'b0, a_lt_b};
                end else begin
                    // Minimum, B wins a tie
                    ordered_result = a_lt_b ? req.operand_a : req.operand_b;
                end
            end
            default: begin
                if (req.flag) begin
                    ordered_result.raw = {31'b0, a_gt_b};
                end else begin
                    // Maximum, B wins a tie
                    ordered_result = a_gt_b ? req.operand_a : req.operand_b;
                end
            end
        endcase
    end

    //==========================================================================
    // NaN handling
    //==========================================================================

    assign any_nan  = is_nan_a_i | is_nan_b_i;
    assign any_snan = is_snan_a_i | is_snan_b_i;

    always_comb begin
        nan_result.raw = '0;
        if (select_mode) begin
            // The non-NaN operand survives, two NaNs give the canonical one
            case ({is_nan_a_i, is_nan_b_i})
                2'b01:   nan_result = req.operand_a;
                2'b10:   nan_result = req.operand_b;
                default: nan_result.raw = CANONICAL_NAN;
            endcase
        end
    end

    // Quiet NaNs are tolerated by EQ and by min/max, signaling NaNs never are
    assign req.invalid_op = select_mode ? any_snan
                                        : (any_nan & (req.operation != FP_EQ)) | any_snan;

    assign req.result    = any_nan ? nan_result : ordered_result;
    assign req.rsp_valid = req.req_valid;

endmodule : float_comparator

/* design/fcmp_wb_regs.sv */
// Wishbone classic register block of the compare unit
// Holds the operands and control, launches a compare on each CTRL write
// and captures the result, done and the sticky invalid bit
`timescale 1ns/1ps

module fcmp_wb_regs import fcmp_pkg::*; #(
    parameter int ADDR_W = 5
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  logic              wb_we_i,
    input  logic [ADDR_W-1:0] wb_adr_i,
    input  logic [31:0]       wb_dat_i,
    // Byte selects are not decoded, every register takes a whole word
    input  logic [3:0]        wb_sel_i,
    output logic [31:0]       wb_dat_o,
    output logic              wb_ack_o,
    input  fclass_t           class_a_i,
    fcmp_req_if.requester     cmp
);

    logic        ack_q;
    logic        wr_en;
    float_word_u opa_q;
    float_word_u opb_q;
    fcomp_uop_t  op_q;
    logic        flag_q;
    logic        launch_q;
    logic [31:0] result_q;
    logic        done_q;
    logic        invalid_q;

    //==========================================================================
    // Handshake
    //==========================================================================

    // Ack follows the request by one clock and never lasts two cycles
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_cyc_i & wb_stb_i & ~ack_q;
        end
    end

    assign wb_ack_o = ack_q;

    // Writes take effect on the edge that closes the ack cycle
    assign wr_en = wb_cyc_i & wb_stb_i & wb_we_i & ack_q;

    //==========================================================================
    // Registers
    //==========================================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            opa_q     <= '0;
            opb_q     <= '0;
            op_q      <= FP_EQ;
            flag_q    <= 1'b0;
            launch_q  <= 1'b0;
            result_q  <= '0;
            done_q    <= 1'b0;
            invalid_q <= 1'b0;
        end else begin
            // The launch pulse lasts exactly one cycle
            launch_q <= 1'b0;

            // Capture while the comparator answers the launched request
            if (cmp.rsp_valid) begin
                result_q  <= cmp.result.raw;
                done_q    <= 1'b1;
                invalid_q <= invalid_q | cmp.invalid_op;
            end

            if (wr_en) begin
                case (wb_adr_i)
                    ADDR_W'(ADDR_OPA): begin
                        opa_q.raw <= wb_dat_i;
                        done_q    <= 1'b0;
                    end
                    ADDR_W'(ADDR_OPB): begin
                        opb_q.raw <= wb_dat_i;
                        done_q    <= 1'b0;
                    end
                    ADDR_W'(ADDR_CTRL): begin
                        op_q     <= fcomp_uop_t'(wb_dat_i[CTRL_OP_MSB:CTRL_OP_LSB]);
                        flag_q   <= wb_dat_i[CTRL_FLAG_BIT];
                        done_q   <= 1'b0;
                        launch_q <= 1'b1;
                    end
                    ADDR_W'(ADDR_STATUS): begin
                        // Write one to clear the sticky invalid bit
                        if (wb_dat_i[STATUS_INVALID_BIT]) begin
                            invalid_q <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    assign cmp.operand_a = opa_q;
    assign cmp.operand_b = opb_q;
    assign cmp.operation = op_q;
    assign cmp.flag      = flag_q;
    assign cmp.req_valid = launch_q;

    //==========================================================================
    // Read path
    //==========================================================================

    always_comb begin
        wb_dat_o = '0;
        case (wb_adr_i)
            ADDR_W'(ADDR_OPA):    wb_dat_o = opa_q.raw;
            ADDR_W'(ADDR_OPB):    wb_dat_o = opb_q.raw;
            ADDR_W'(ADDR_CTRL): begin
                wb_dat_o[CTRL_OP_MSB:CTRL_OP_LSB] = op_q;
                wb_dat_o[CTRL_FLAG_BIT]           = flag_q;
            end
            ADDR_W'(ADDR_RESULT): wb_dat_o = result_q;
            ADDR_W'(ADDR_STATUS): begin
                wb_dat_o[STATUS_DONE_BIT]    = done_q;
                wb_dat_o[STATUS_INVALID_BIT] = invalid_q;
            end
            ADDR_W'(ADDR_CLASS):  wb_dat_o = {22'b0, class_a_i};
            // Unmapped offsets read as zero
            default:              wb_dat_o = '0;
        endcase
    end

endmodule : fcmp_wb_regs

/* design/fcmp_top.sv */
// Floating-point compare unit top level
// Wishbone classic slave in front of two classifiers and the comparator
`timescale 1ns/1ps

module fcmp_top import fcmp_pkg::*; #(
    parameter int ADDR_W = 5
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  logic              wb_we_i,
    input  logic [ADDR_W-1:0] wb_adr_i,
    input  logic [31:0]       wb_dat_i,
    input  logic [3:0]        wb_sel_i,
    output logic [31:0]       wb_dat_o,
    output logic              wb_ack_o
);

    logic    nan_a;
    logic    nan_b;
    logic    snan_a;
    logic    snan_b;
    fclass_t class_a;

    fcmp_req_if u_req_if ();

    fcmp_wb_regs #(
        .ADDR_W (ADDR_W)
    ) u_regs (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_sel_i  (wb_sel_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o),
        .class_a_i (class_a),
        .cmp       (u_req_if.requester)
    );

    // Operand A also feeds the CLASS register
    float_classifier u_class_a (
        .operand_i (u_req_if.operand_a),
        .is_nan_o  (nan_a),
        .is_snan_o (snan_a),
        .class_o   (class_a)
    );

    // Only the NaN flags of operand B are needed
    float_classifier u_class_b (
        .operand_i (u_req_if.operand_b),
        .is_nan_o  (nan_b),
        .is_snan_o (snan_b),
        .class_o   ()
    );

    float_comparator u_comparator (
        .req         (u_req_if.responder),
        .is_nan_a_i  (nan_a),
        .is_nan_b_i  (nan_b),
        .is_snan_a_i (snan_a),
        .is_snan_b_i (snan_b)
    );

endmodule : fcmp_top

/* tb/fcmp_tb.sv */
// Testbench for the floating-point compare unit
// Drives the Wishbone slave from a table of compares, then checks sticky
// invalid, the class mask and a random ordering sweep against a model
`timescale 1ns/1ps

module fcmp_tb import fcmp_pkg::*; ();

    localparam int ADDR_W     = 5;
    localparam int RAND_PAIRS = 40;

    typedef struct packed {
        logic [31:0] a;
        logic [31:0] b;
        logic [1:0]  op;
        logic        flag;
        logic [31:0] res;
        logic        inv;
        logic        done;
    } row_t;

    logic              clk;
    logic              rst_n;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [ADDR_W-1:0] wb_adr;
    logic [31:0]       wb_dat_w;
    logic [3:0]        wb_sel;
    logic [31:0]       wb_dat_r;
    logic              wb_ack;

    row_t   rows[$];
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    int     cycle_limit = 0;
    integer seed = 32'hc0c3;

    fcmp_top #(
        .ADDR_W (ADDR_W)
    ) UUT (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_sel_i (wb_sel),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Hard stop in case the bus or the DUT stalls
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run went past %0d clock cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    //==========================================================================
    // Bus access and checking helpers
    //==========================================================================

    // Entered 1 ns after a rising edge, and returns at the same phase
    task automatic bus_cycle(input logic we, input logic [7:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        rdata = '0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = ADDR_W'(addr);
        wb_dat_w = wdata;
        wb_sel = 4'hF;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!wb_ack && waited < 4);
        if (wb_ack) begin
            rdata = wb_dat_r;
            // Ack belongs in the cycle right after the request
            if (waited != 1) begin
                $display("ack at address %h came after %0d cycles instead of one",
                         addr, waited);
                errors++;
            end
            // The slave takes write data on the edge that ends the ack cycle
            @(posedge clk);
            #1;
            // Stb is still high here, so a second ack cycle would show up now
            expect_word("wb_ack after ack cycle", 32'h0, {31'b0, wb_ack});
        end else begin
            $display("%s at address %h: ack never came", we ? "wb_write" : "wb_read", addr);
            errors++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic wb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] ignored;
        bus_cycle(1'b1, addr, data, ignored);
    endtask

    task automatic wb_read(input logic [7:0] addr, output logic [31:0] data);
        bus_cycle(1'b0, addr, 32'h0, data);
    endtask

    task automatic expect_word(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // Signed magnitude turned into a signed key gives the IEEE order of
    // non-NaN values, with both zeros landing on the same key
    function automatic logic lt_by_order(input logic [31:0] a, input logic [31:0] b);
        logic signed [32:0] key_a;
        logic signed [32:0] key_b;
        key_a = $signed({2'b00, a[30:0]});
        key_b = $signed({2'b00, b[30:0]});
        if (a[31]) key_a = -key_a;
        if (b[31]) key_b = -key_b;
        return key_a < key_b;
    endfunction

    task automatic add_row(input logic [31:0] a, input logic [31:0] b, input logic [1:0] op,
                           input logic flag, input logic [31:0] res, input logic inv);
        row_t r;
        r.a = a;
        r.b = b;
        r.op = op;
        r.flag = flag;
        r.res = res;
        r.inv = inv;
        r.done = 1'b1;
        rows.push_back(r);
    endtask

    //==========================================================================
    // Stimulus
    //==========================================================================

    initial begin
        logic [31:0] rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] class_vals[10];
        rst_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        wb_sel = 4'h0;

        // Flag form across signs, exponents, significands and zeros
        add_row(32'h3F800000, 32'h40000000, FP_LT, 1'b1, 32'h1, 1'b0);
        add_row(32'h40000000, 32'h3F800000, FP_LT, 1'b1, 32'h0, 1'b0);
        add_row(32'hBF800000, 32'h3F800000, FP_LT, 1'b1, 32'h1, 1'b0);
        add_row(32'h3F800000, 32'hBF800000, FP_LT, 1'b1, 32'h0, 1'b0);
        add_row(32'hC0000000, 32'hBF800000, FP_LT, 1'b1, 32'h1, 1'b0);
        add_row(32'hBF800000, 32'hBFC00000, FP_GT, 1'b1, 32'h1, 1'b0);
        add_row(32'h3F800000, 32'h3FC00000, FP_LE, 1'b1, 32'h1, 1'b0);
        add_row(32'h3FC00000, 32'h3F800000, FP_LE, 1'b1, 32'h0, 1'b0);
        add_row(32'h3FC00000, 32'h3FC00000, FP_EQ, 1'b1, 32'h1, 1'b0);
        add_row(32'h3F800000, 32'h3FC00000, FP_EQ, 1'b1, 32'h0, 1'b0);
        add_row(32'h00000000, 32'h80000000, FP_EQ, 1'b1, 32'h1, 1'b0);
        add_row(32'h80000000, 32'h00000000, FP_LT, 1'b1, 32'h0, 1'b0);
        add_row(32'h80000000, 32'h00000000, FP_LE, 1'b1, 32'h1, 1'b0);
        add_row(32'h3F800000, 32'h3F800000, FP_GT, 1'b1, 32'h0, 1'b0);
        add_row(32'hBF800000, 32'hBF800000, FP_LE, 1'b1, 32'h1, 1'b0);
        add_row(32'hFF800000, 32'h7F800000, FP_LT, 1'b1, 32'h1, 1'b0);
        // Min and max, B wins a tie
        add_row(32'h3F800000, 32'h40000000, FP_LT, 1'b0, 32'h3F800000, 1'b0);
        add_row(32'hBF800000, 32'hC0000000, FP_LT, 1'b0, 32'hC0000000, 1'b0);
        add_row(32'h3F800000, 32'hBF800000, FP_GT, 1'b0, 32'h3F800000, 1'b0);
        add_row(32'h00000000, 32'h80000000, FP_LT, 1'b0, 32'h80000000, 1'b0);
        add_row(32'h80000000, 32'h00000000, FP_GT, 1'b0, 32'h00000000, 1'b0);
        // Quiet and signaling NaNs
        add_row(32'h7FC00000, 32'h3F800000, FP_LT, 1'b1, 32'h0, 1'b1);
        add_row(32'h7FC00000, 32'h3F800000, FP_EQ, 1'b1, 32'h0, 1'b0);
        add_row(32'h3F800000, 32'h7FC00000, FP_LT, 1'b0, 32'h3F800000, 1'b0);
        add_row(32'h7FC00000, 32'h40000000, FP_GT, 1'b0, 32'h40000000, 1'b0);
        add_row(32'h7FC00000, 32'h7FC00001, FP_LT, 1'b0, 32'h7FC00000, 1'b0);
        add_row(32'h7F800001, 32'h3F800000, FP_EQ, 1'b1, 32'h0, 1'b1);
        add_row(32'h3F800000, 32'h7F800001, FP_GT, 1'b0, 32'h3F800000, 1'b1);
        add_row(32'h7F800001, 32'h7FC00000, FP_LT, 1'b0, 32'h7FC00000, 1'b1);
        add_row(32'h7F800001, 32'h3F800000, FP_LE, 1'b1, 32'h0, 1'b1);

        cycle_limit = (rows.size() + RAND_PAIRS) * 24 + 200;

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Reset values, operand read back and an unmapped offset
        wb_read(ADDR_RESULT, rd);
        expect_word("RESULT after reset", 32'h0, rd);
        wb_read(ADDR_STATUS, rd);
        expect_word("STATUS after reset", 32'h0, rd);
        wb_read(ADDR_CTRL, rd);
        expect_word("CTRL after reset", 32'h0, rd);
        wb_write(ADDR_OPA, 32'hA5A50F0F);
        wb_write(ADDR_OPB, 32'h13579BDF);
        wb_read(ADDR_OPA, rd);
        expect_word("OPA", 32'hA5A50F0F, rd);
        wb_read(ADDR_OPB, rd);
        expect_word("OPB", 32'h13579BDF, rd);
        wb_read(8'h18, rd);
        expect_word("unmapped 0x18", 32'h0, rd);

        foreach (rows[i]) begin
            wb_write(ADDR_OPA, rows[i].a);
            wb_write(ADDR_OPB, rows[i].b);
            wb_write(ADDR_CTRL, {29'b0, rows[i].flag, rows[i].op});
            wb_read(ADDR_RESULT, rd);
            expect_word($sformatf("RESULT row %0d", i), rows[i].res, rd);
            wb_read(ADDR_STATUS, rd);
            expect_word($sformatf("STATUS row %0d", i), {30'b0, rows[i].inv, rows[i].done}, rd);
            wb_write(ADDR_STATUS, 32'h2);
        end

        // Invalid survives a clean compare until it is cleared by hand
        wb_write(ADDR_OPA, 32'h7F800001);
        wb_write(ADDR_OPB, 32'h3F800000);
        wb_write(ADDR_CTRL, {29'b0, 1'b1, FP_LT});
        wb_write(ADDR_OPA, 32'h3F800000);
        wb_write(ADDR_OPB, 32'h40000000);
        wb_write(ADDR_CTRL, {29'b0, 1'b1, FP_LT});
        wb_read(ADDR_RESULT, rd);
        expect_word("RESULT clean compare", 32'h1, rd);
        wb_read(ADDR_STATUS, rd);
        expect_word("STATUS sticky invalid", 32'h3, rd);
        wb_write(ADDR_STATUS, 32'h2);
        wb_read(ADDR_STATUS, rd);
        expect_word("STATUS after clear", 32'h1, rd);

        // One value per class, in the fclass bit order
        class_vals = '{32'hFF800000, 32'hBF800000, 32'h80000001, 32'h80000000, 32'h00000000,
                       32'h00000001, 32'h3F800000, 32'h7F800000, 32'h7F800001, 32'h7FC00000};
        for (int c = 0; c < 10; c++) begin
            wb_write(ADDR_OPA, class_vals[c]);
            wb_read(ADDR_CLASS, rd);
            expect_word($sformatf("CLASS of %h", class_vals[c]), 32'h1 << c, rd);
        end

        // Random pairs without NaNs, some with shared exponents or equal values
        for (int p = 0; p < RAND_PAIRS; p++) begin
            a = $random(seed);
            b = $random(seed);
            if (p % 4 == 1) b[30:23] = a[30:23];
            if (p % 8 == 3) b = a;
            if (p % 8 == 5) b = a ^ 32'h80000000;
            if (&a[30:23]) a[30] = 1'b0;
            if (&b[30:23]) b[30] = 1'b0;
            wb_write(ADDR_OPA, a);
            wb_write(ADDR_OPB, b);
            wb_write(ADDR_CTRL, {29'b0, 1'b1, FP_LT});
            wb_read(ADDR_RESULT, rd);
            expect_word($sformatf("RESULT lt %h %h", a, b), {31'b0, lt_by_order(a, b)}, rd);
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : fcmp_tb

/* compile.f */
design/fcmp_pkg.sv
design/fcmp_req_if.sv
design/float_classifier.sv
design/float_comparator.sv
design/fcmp_wb_regs.sv
design/fcmp_top.sv
tb/fcmp_tb.sv

/* run.sh */
#!/bin/sh
# Build the compare unit testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" \
    && verilator --binary --timing --top-module fcmp_tb -f compile.f -o fcmp_sim \
    && ./obj_dir/fcmp_sim | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
